/* src/uart_dbg_config.svh */
// Build settings for the UART debug server, included by the RTL and the testbench
`ifndef UART_DBG_CONFIG_SVH
`define UART_DBG_CONFIG_SVH

////////////////////
// Serial timing
////////////////////

// Clock cycles per serial bit
`define UART_DBG_CLKS_PER_BIT 16

// 1 adds an even parity bit after the data bits
`define UART_DBG_PARITY_EN 1

////////////////////
// Local memory
////////////////////

// Bytes of local memory, a power of two
`define UART_DBG_MEM_DEPTH 256

`endif

/* src/uart_dbg_pkg.sv */
// Shared types, protocol byte codes and engine states of the UART debug server
`default_nettype none

`include "uart_dbg_config.svh"

package uart_dbg_pkg;

  typedef logic [7:0]  dbg_byte_t;
  typedef logic [63:0] dbg_addr_t;
  typedef logic [63:0] dbg_len_t;
  typedef logic [31:0] dbg_word_t;

  // Local memory index, wraps at the memory depth
  typedef logic [$clog2(`UART_DBG_MEM_DEPTH)-1:0] mem_idx_t;

  // Protocol byte codes
  localparam dbg_byte_t CMD_READ  = 8'h11;
  localparam dbg_byte_t CMD_WRITE = 8'h12;
  localparam dbg_byte_t CMD_EXEC  = 8'h13;
  localparam dbg_byte_t CODE_ACK  = 8'h06;
  localparam dbg_byte_t CODE_EOT  = 8'h04;
  localparam dbg_byte_t CODE_EOC  = 8'h14;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_HDR_ADDR,
    ST_HDR_LEN,
    ST_EXEC_ADDR,
    ST_ACK,
    ST_RD_FETCH,
    ST_RD_LOAD,
    ST_RD_SEND,
    ST_WR_DATA,
    ST_LAST,
    ST_EOC
  } dbg_state_e;

endpackage

`default_nettype wire

/* src/uart_byte_if.sv */
// Byte stream between the UART receiver or transmitter and the command engine
`timescale 1ns/1ps
`default_nettype none

interface uart_byte_if;
  import uart_dbg_pkg::*;

  logic      valid;
  logic      ready;
  dbg_byte_t data;
  logic      err;

  // Producer side
  modport src (
    output valid,
    output data,
    output err,
    input  ready
  );

  // Consumer side
  modport snk (
    input  valid,
    input  data,
    input  err,
    output ready
  );

endinterface

`default_nettype wire

/* src/uart_rx.sv */
// UART receiver: samples the line mid-bit and strobes each byte or a framing error
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_config.svh"

module uart_rx (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     rx_i,
  uart_byte_if.src byte_o
);
  import uart_dbg_pkg::*;

  localparam int               CPB      = `UART_DBG_CLKS_PER_BIT;
  localparam int               CNT_W    = $clog2(CPB);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CPB - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CPB / 2 - 1);
  localparam bit               PAR_EN   = (`UART_DBG_PARITY_EN != 0);

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

  rx_state_e        state_q;
  logic [1:0]       sync_q;
  logic             rx_s;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_cnt_q;
  dbg_byte_t        shreg_q;
  logic             par_err_q;
  logic             valid_q;
  logic             err_q;
  logic             bit_tick;

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  assign rx_s     = sync_q[1];
  assign bit_tick = (clk_cnt_q == BIT_END);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      par_err_q <= 1'b0;
      valid_q   <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      valid_q   <= 1'b0;
      err_q     <= 1'b0;
      clk_cnt_q <= bit_tick ? '0 : clk_cnt_q + CNT_W'(1);
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (!rx_s) state_q <= RX_START;
        end
        RX_START: begin
          // Glitches shorter than half a bit fall back to idle
          if (clk_cnt_q == HALF_END) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            par_err_q <= 1'b0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            shreg_q   <= {rx_s, shreg_q[7:1]};
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) state_q <= PAR_EN ? RX_PARITY : RX_STOP;
          end
        end
        RX_PARITY: begin
          if (bit_tick) begin
            par_err_q <= rx_s ^ (^shreg_q);
            state_q   <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            if (rx_s && !par_err_q) valid_q <= 1'b1;
            else err_q <= 1'b1;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  assign byte_o.valid = valid_q;
  assign byte_o.err   = err_q;
  assign byte_o.data  = shreg_q;

endmodule

`default_nettype wire

/* src/uart_tx.sv */
// UART transmitter: serializes one accepted byte at a time, line idles high
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_config.svh"

module uart_tx (
  input  logic     clk,
  input  logic     rst_i,
  uart_byte_if.snk byte_i,
  output logic     tx_o
);
  import uart_dbg_pkg::*;

  localparam int               CPB     = `UART_DBG_CLKS_PER_BIT;
  localparam int               CNT_W   = $clog2(CPB);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CPB - 1);
  localparam bit               PAR_EN  = (`UART_DBG_PARITY_EN != 0);

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

  tx_state_e        state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_cnt_q;
  dbg_byte_t        shreg_q;
  logic             par_q;
  logic             line_q;
  logic             bit_tick;
  logic             accept;

  assign byte_i.ready = (state_q == TX_IDLE);
  assign accept       = byte_i.valid & byte_i.ready;
  assign bit_tick     = (clk_cnt_q == BIT_END);
  assign tx_o         = line_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= TX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      line_q    <= 1'b1;
    end else begin
      clk_cnt_q <= bit_tick ? '0 : clk_cnt_q + CNT_W'(1);
      case (state_q)
        TX_IDLE: begin
          clk_cnt_q <= '0;
          // Start bit goes out on the cycle after acceptance
          if (accept) begin
            shreg_q <= byte_i.data;
            par_q   <= ^byte_i.data;
            line_q  <= 1'b0;
            state_q <= TX_START;
          end
        end
        TX_START: begin
          if (bit_tick) begin
            line_q    <= shreg_q[0];
            shreg_q   <= shreg_q >> 1;
            bit_cnt_q <= '0;
            state_q   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_tick) begin
            if (bit_cnt_q == 3'd7) begin
              line_q  <= PAR_EN ? par_q : 1'b1;
              state_q <= PAR_EN ? TX_PARITY : TX_STOP;
            end else begin
              line_q    <= shreg_q[0];
              shreg_q   <= shreg_q >> 1;
              bit_cnt_q <= bit_cnt_q + 3'd1;
            end
          end
        end
        TX_PARITY: begin
          if (bit_tick) begin
            line_q  <= 1'b1;
            state_q <= TX_STOP;
          end
        end
        TX_STOP: begin
          if (bit_tick) state_q <= TX_IDLE;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/dbg_mem.sv */
// Byte-wide local memory with one write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_config.svh"

module dbg_mem (
  input  logic                    clk,
  input  logic                    we_i,
  input  uart_dbg_pkg::mem_idx_t  waddr_i,
  input  uart_dbg_pkg::dbg_byte_t wdata_i,
  input  uart_dbg_pkg::mem_idx_t  raddr_i,
  output uart_dbg_pkg::dbg_byte_t rdata_o
);
  import uart_dbg_pkg::*;

  dbg_byte_t mem_q [`UART_DBG_MEM_DEPTH];

  // Read data follows the index by one cycle
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
    rdata_o <= mem_q[raddr_i];
  end

endmodule

`default_nettype wire

/* src/dbg_cmd_engine.sv */
// Debug protocol engine: decodes host commands, moves memory bytes, reports exec and EOC
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_engine (
  input  logic                    clk,
  input  logic                    rst_i,
  uart_byte_if.snk                rx_i,
  uart_byte_if.src                tx_o,
  output logic                    mem_we_o,
  output uart_dbg_pkg::mem_idx_t  mem_waddr_o,
  output uart_dbg_pkg::dbg_byte_t mem_wdata_o,
  output uart_dbg_pkg::mem_idx_t  mem_raddr_o,
  input  uart_dbg_pkg::dbg_byte_t mem_rdata_i,
  output logic                    exec_o,
  output uart_dbg_pkg::dbg_addr_t exec_addr_o,
  input  logic                    eoc_i,
  input  uart_dbg_pkg::dbg_word_t exit_code_i,
  output logic                    busy_o
);
  import uart_dbg_pkg::*;

  localparam int IDX_W = $bits(mem_idx_t);

  dbg_state_e state_q;
  dbg_byte_t  cmd_q;
  dbg_addr_t  addr_q;
  dbg_len_t   len_q;
  dbg_len_t   offs_q;
  dbg_word_t  code_q;
  dbg_byte_t  tx_data_q;
  logic       tx_valid_q;
  logic [2:0] cnt_q;
  logic       exec_q;
  mem_idx_t   cur_idx;
  logic       rx_hit;
  logic       tx_done;
  logic       last_byte;

  ////////////////////
  // Datapath
  ////////////////////

  assign rx_hit    = rx_i.valid;
  assign tx_done   = tx_valid_q & tx_o.ready;
  assign last_byte = (offs_q + dbg_len_t'(1) == len_q);

  // Address wraps at the memory depth
  assign cur_idx = addr_q[IDX_W-1:0] + offs_q[IDX_W-1:0];

  // Receiver has no back-pressure
  assign rx_i.ready = 1'b1;

  assign tx_o.valid = tx_valid_q;
  assign tx_o.data  = tx_data_q;
  assign tx_o.err   = 1'b0;

  assign mem_we_o    = (state_q == ST_WR_DATA) & rx_hit;
  assign mem_waddr_o = cur_idx;
  assign mem_wdata_o = rx_i.data;
  assign mem_raddr_o = cur_idx;

  assign exec_o      = exec_q;
  assign exec_addr_o = addr_q;
  assign busy_o      = (state_q != ST_IDLE);

  ////////////////////
  // Protocol FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      tx_valid_q <= 1'b0;
      cnt_q      <= '0;
      offs_q     <= '0;
      exec_q     <= 1'b0;
    end else begin
      exec_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          cnt_q  <= '0;
          offs_q <= '0;
          if (rx_hit) begin
            cmd_q <= rx_i.data;
            case (rx_i.data)
              CODE_ACK: begin
                tx_data_q  <= CODE_ACK;
                tx_valid_q <= 1'b1;
                state_q    <= ST_LAST;
              end
              CMD_READ, CMD_WRITE: state_q <= ST_HDR_ADDR;
              CMD_EXEC: state_q <= ST_EXEC_ADDR;
              default: state_q <= ST_IDLE;
            endcase
          end else if (eoc_i) begin
            code_q     <= exit_code_i;
            tx_data_q  <= CODE_EOC;
            tx_valid_q <= 1'b1;
            state_q    <= ST_EOC;
          end
        end
        // Address bytes arrive LSB first
        ST_HDR_ADDR, ST_EXEC_ADDR: begin
          if (rx_hit) begin
            addr_q <= {rx_i.data, addr_q[63:8]};
            cnt_q  <= cnt_q + 3'd1;
            if (cnt_q == 3'd7) begin
              if (state_q == ST_EXEC_ADDR) begin
                exec_q     <= 1'b1;
                tx_data_q  <= CODE_ACK;
                tx_valid_q <= 1'b1;
                state_q    <= ST_LAST;
              end else begin
                state_q <= ST_HDR_LEN;
              end
            end
          end
        end
        ST_HDR_LEN: begin
          if (rx_hit) begin
            len_q <= {rx_i.data, len_q[63:8]};
            cnt_q <= cnt_q + 3'd1;
            if (cnt_q == 3'd7) begin
              tx_data_q  <= CODE_ACK;
              tx_valid_q <= 1'b1;
              state_q    <= ST_ACK;
            end
          end
        end
        ST_ACK: begin
          if (tx_done) begin
            if (len_q == '0) begin
              tx_data_q <= CODE_EOT;
              state_q   <= ST_LAST;
            end else begin
              tx_valid_q <= 1'b0;
              state_q    <= (cmd_q == CMD_READ) ? ST_RD_FETCH : ST_WR_DATA;
            end
          end
        end
        // Index is presented here, data comes back next cycle
        ST_RD_FETCH: state_q <= ST_RD_LOAD;
        ST_RD_LOAD: begin
          tx_data_q  <= mem_rdata_i;
          tx_valid_q <= 1'b1;
          state_q    <= ST_RD_SEND;
        end
        ST_RD_SEND: begin
          if (tx_done) begin
            offs_q <= offs_q + dbg_len_t'(1);
            if (last_byte) begin
              tx_data_q <= CODE_EOT;
              state_q   <= ST_LAST;
            end else begin
              tx_valid_q <= 1'b0;
              state_q    <= ST_RD_FETCH;
            end
          end
        end
        ST_WR_DATA: begin
          if (rx_hit) begin
            offs_q <= offs_q + dbg_len_t'(1);
            if (last_byte) begin
              tx_data_q  <= CODE_EOT;
              tx_valid_q <= 1'b1;
              state_q    <= ST_LAST;
            end
          end
        end
        ST_LAST: begin
          if (tx_done) begin
            tx_valid_q <= 1'b0;
            state_q    <= ST_IDLE;
          end
        end
        // EOC byte first, then four exit code bytes LSB first
        ST_EOC: begin
          if (tx_done) begin
            if (cnt_q == 3'd4) begin
              tx_valid_q <= 1'b0;
              state_q    <= ST_IDLE;
            end else begin
              tx_data_q <= code_q[7:0];
              code_q    <= code_q >> 8;
              cnt_q     <= cnt_q + 3'd1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/uart_dbg_top.sv */
// Top level of the UART debug server: receiver, transmitter, command engine and memory
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_top (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    uart_rx_i,
  output logic                    uart_tx_o,
  output logic                    exec_o,
  output uart_dbg_pkg::dbg_addr_t exec_addr_o,
  input  logic                    eoc_i,
  input  uart_dbg_pkg::dbg_word_t exit_code_i,
  output logic                    busy_o,
  output logic                    rx_err_o
);
  import uart_dbg_pkg::*;

  uart_byte_if rx_bus ();
  uart_byte_if tx_bus ();

  logic      mem_we;
  mem_idx_t  mem_waddr;
  mem_idx_t  mem_raddr;
  dbg_byte_t mem_wdata;
  dbg_byte_t mem_rdata;

  uart_rx i_uart_rx (
    .clk   (clk),
    .rst_i (rst_i),
    .rx_i  (uart_rx_i),
    .byte_o(rx_bus)
  );

  uart_tx i_uart_tx (
    .clk   (clk),
    .rst_i (rst_i),
    .byte_i(tx_bus),
    .tx_o  (uart_tx_o)
  );

  dbg_cmd_engine i_dbg_cmd_engine (
    .clk        (clk),
    .rst_i      (rst_i),
    .rx_i       (rx_bus),
    .tx_o       (tx_bus),
    .mem_we_o   (mem_we),
    .mem_waddr_o(mem_waddr),
    .mem_wdata_o(mem_wdata),
    .mem_raddr_o(mem_raddr),
    .mem_rdata_i(mem_rdata),
    .exec_o     (exec_o),
    .exec_addr_o(exec_addr_o),
    .eoc_i      (eoc_i),
    .exit_code_i(exit_code_i),
    .busy_o     (busy_o)
  );

  dbg_mem i_dbg_mem (
    .clk    (clk),
    .we_i   (mem_we),
    .waddr_i(mem_waddr),
    .wdata_i(mem_wdata),
    .raddr_i(mem_raddr),
    .rdata_o(mem_rdata)
  );

  // Parity or stop-bit failure strobe
  assign rx_err_o = rx_bus.err;

endmodule

`default_nettype wire

/* tests/tb_uart_host.svh */
// Host-side tasks included by the testbench to frame bytes and run debug commands
`ifndef TB_UART_HOST_SVH
`define TB_UART_HOST_SVH

////////////////////
// Serial framing
////////////////////

// One bit time on the line entered at a rising edge
task automatic drive_bit(input logic b);
  uart_rx_i <= b;
  repeat (CPB) @(posedge clk);
endtask

// Start, data LSB first, parity when enabled, stop
task automatic send_byte(input dbg_byte_t b, input bit bad_parity);
  dbg_byte_t sh;
  int        i;
  sh = b;
  @(posedge clk);
  drive_bit(1'b0);
  for (i = 0; i < 8; i++) begin
    drive_bit(sh[0]);
    sh = sh >> 1;
  end
  if (PAR_EN) begin
    drive_bit((^b) ^ bad_parity);
  end
  drive_bit(1'b1);
endtask

// 64-bit header field sent LSB byte first
task automatic send_field(input logic [63:0] v);
  int i;
  for (i = 0; i < 8; i++) begin
    send_byte(dbg_byte_t'(v >> (8 * i)), 1'b0);
  end
endtask

// Samples one frame from the DUT near the middle of each bit
task automatic recv_byte(output dbg_byte_t b, output bit frame_ok);
  int i;
  @(negedge uart_tx_o);
  repeat (CPB / 2) @(negedge clk);
  frame_ok = (uart_tx_o == 1'b0);
  for (i = 0; i < 8; i++) begin
    repeat (CPB) @(negedge clk);
    b = {uart_tx_o, b[7:1]};
  end
  if (PAR_EN) begin
    repeat (CPB) @(negedge clk);
    if (uart_tx_o != ^b) frame_ok = 1'b0;
  end
  repeat (CPB) @(negedge clk);
  if (uart_tx_o != 1'b1) frame_ok = 1'b0;
endtask

////////////////////
// Transactions
////////////////////

task automatic push_reply(input dbg_byte_t cmd, input dbg_addr_t addr, input dbg_len_t len,
                          input dbg_word_t code, input int first, input int last);
  int pos;
  for (pos = first; pos <= last; pos++) begin
    exp_q.push_back(ref_reply(cmd, addr, len, code, pos));
  end
endtask

// Waits for all expected bytes and then a quiet gap where any extra byte would show up
task automatic wait_replies();
  while (exp_q.size() != 0) @(posedge clk);
  repeat (SETTLE_FRAMES * 12 * CPB) @(posedge clk);
endtask

task automatic run_challenge(input bit bad_parity);
  int errs;
  errs = rx_err_cnt;
  if (!bad_parity) push_reply(CODE_ACK, '0, '0, '0, 0, 0);
  send_byte(CODE_ACK, bad_parity);
  wait_replies();
  check_count("rx_err_o pulses", rx_err_cnt - errs, bad_parity ? 1 : 0);
endtask

// Header, wait for ACK, then the data bytes
task automatic run_write(input dbg_addr_t addr, input dbg_len_t len);
  dbg_byte_t d;
  int        i;
  push_reply(CMD_WRITE, addr, len, '0, 0, 0);
  send_byte(CMD_WRITE, 1'b0);
  send_field(addr);
  send_field(len);
  while (exp_q.size() != 0) @(posedge clk);
  for (i = 0; i < int'(len); i++) begin
    d = dbg_byte_t'($random(seed));
    model_mem[mem_index(addr, dbg_len_t'(i))] = d;
    send_byte(d, 1'b0);
  end
  push_reply(CMD_WRITE, addr, len, '0, 1, 1);
  wait_replies();
endtask

task automatic run_read(input dbg_addr_t addr, input dbg_len_t len);
  push_reply(CMD_READ, addr, len, '0, 0, int'(len) + 1);
  send_byte(CMD_READ, 1'b0);
  send_field(addr);
  send_field(len);
  wait_replies();
endtask

task automatic run_exec(input dbg_addr_t addr);
  int pulses;
  pulses = exec_cnt;
  push_reply(CMD_EXEC, addr, '0, '0, 0, 0);
  send_byte(CMD_EXEC, 1'b0);
  send_field(addr);
  wait_replies();
  check_count("exec_o pulses", exec_cnt - pulses, 1);
  check_addr("exec_addr_o", exec_addr_seen, addr);
endtask

task automatic run_eoc(input dbg_word_t code);
  @(negedge clk);
  check_level("busy_o", busy_o, 1'b0);
  push_reply(CODE_EOC, '0, '0, code, 0, 4);
  @(posedge clk);
  eoc_i       <= 1'b1;
  exit_code_i <= code;
  @(posedge clk);
  eoc_i <= 1'b0;
  wait_replies();
endtask

`endif

/* tests/tb_uart_dbg_top.sv */
// Testbench for the UART debug server that plays the host and checks every reply byte
`timescale 1ns/1ps
`default_nettype none

`include "uart_dbg_config.svh"

module tb_uart_dbg_top;
  import uart_dbg_pkg::*;

  localparam int CPB           = `UART_DBG_CLKS_PER_BIT;
  localparam bit PAR_EN        = (`UART_DBG_PARITY_EN != 0);
  localparam int MEM_DEPTH     = `UART_DBG_MEM_DEPTH;
  localparam int IDX_W         = $clog2(MEM_DEPTH);
  localparam int RW_ROUNDS     = 3;
  localparam int MAX_LEN       = 16;
  localparam int SETTLE_FRAMES = 2;
  // Challenges, write and read pairs, exec, EOC
  localparam int TXNS          = 3 + 2 * (RW_ROUNDS + 1) + 2;
  // Bytes on both lines plus the quiet gaps in frames
  localparam int TOTAL_FRAMES  = 3 * 2 + (RW_ROUNDS + 1) * (2 * 17 + 2 * MAX_LEN + 4)
                                 + 10 + 5 + TXNS * SETTLE_FRAMES;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_FRAMES * 12 * CPB + 10;

  logic      clk;
  logic      rst_i;
  logic      uart_rx_i;
  logic      uart_tx_o;
  logic      exec_o;
  dbg_addr_t exec_addr_o;
  logic      eoc_i;
  dbg_word_t exit_code_i;
  logic      busy_o;
  logic      rx_err_o;

  integer    seed = 32'h059fa0e8;
  int        mismatch_cnt = 0;
  int        other_err_cnt = 0;
  int        cycle_cnt = 0;
  int        exec_cnt = 0;
  int        rx_err_cnt = 0;
  dbg_addr_t exec_addr_seen;
  dbg_byte_t exp_q [$];
  dbg_byte_t model_mem [MEM_DEPTH];

  uart_dbg_top uart_dbg_top_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .uart_rx_i  (uart_rx_i),
    .uart_tx_o  (uart_tx_o),
    .exec_o     (exec_o),
    .exec_addr_o(exec_addr_o),
    .eoc_i      (eoc_i),
    .exit_code_i(exit_code_i),
    .busy_o     (busy_o),
    .rx_err_o   (rx_err_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Memory index of a transfer byte wrapping at the depth
  function automatic mem_idx_t mem_index(input dbg_addr_t addr, input dbg_len_t offs);
    dbg_addr_t sum;
    sum = addr + offs;
    return mem_idx_t'(sum % dbg_addr_t'(MEM_DEPTH));
  endfunction

  // Byte number pos of the server's reply to cmd
  function automatic dbg_byte_t ref_reply(input dbg_byte_t cmd, input dbg_addr_t addr,
                                          input dbg_len_t len, input dbg_word_t code,
                                          input int pos);
    dbg_byte_t b;
    case (cmd)
      CMD_READ: begin
        if (pos == 0) b = CODE_ACK;
        else if (dbg_len_t'(pos) <= len) b = model_mem[mem_index(addr, dbg_len_t'(pos - 1))];
        else b = CODE_EOT;
      end
      CMD_WRITE: b = (pos == 0) ? CODE_ACK : CODE_EOT;
      CODE_EOC: b = (pos == 0) ? CODE_EOC : dbg_byte_t'(code >> (8 * (pos - 1)));
      default: b = CODE_ACK;
    endcase
    return b;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_byte(input string name, input dbg_byte_t got, input dbg_byte_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%02h, expected 0x%02h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input dbg_addr_t got, input dbg_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%016h, expected 0x%016h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // Single-bit output levels
  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  `include "tb_uart_host.svh"

  // Strobes and cycles counted mid-cycle
  always @(negedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (exec_o) begin
      exec_cnt       = exec_cnt + 1;
      exec_addr_seen = exec_addr_o;
    end
    if (rx_err_o) rx_err_cnt = rx_err_cnt + 1;
  end

  // Every byte from the DUT against the expected queue
  initial begin : tx_monitor
    dbg_byte_t rx_b;
    bit        frame_ok;
    @(negedge rst_i);
    forever begin
      recv_byte(rx_b, frame_ok);
      if (!frame_ok) begin
        $display("ERROR: bad parity or stop bit on uart_tx_o, byte 0x%02h", rx_b);
        other_err_cnt++;
      end else if (exp_q.size() == 0) begin
        $display("ERROR: unexpected byte 0x%02h on uart_tx_o", rx_b);
        other_err_cnt++;
      end else begin
        check_byte("uart_tx_o byte", rx_b, exp_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) @(posedge clk);
    $display("ERROR: timeout after %0d cycles with %0d replies pending", cycle_cnt, exp_q.size());
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    dbg_addr_t addr;
    dbg_addr_t alias_addr;
    dbg_len_t  len;
    int        round;
    rst_i       <= 1'b1;
    uart_rx_i   <= 1'b1;
    eoc_i       <= 1'b0;
    exit_code_i <= '0;
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check_level("uart_tx_o", uart_tx_o, 1'b1);
    check_level("exec_o", exec_o, 1'b0);
    check_level("rx_err_o", rx_err_o, 1'b0);
    check_level("busy_o", busy_o, 1'b0);
    run_challenge(1'b0);
    for (round = 0; round < RW_ROUNDS; round++) begin
      addr = {$random(seed), $random(seed)};
      len  = dbg_len_t'(1 + ($unsigned($random(seed)) % MAX_LEN));
      run_write(addr, len);
      run_read(addr, len);
    end
    // Differs only above the index bits
    addr       = {$random(seed), $random(seed)};
    alias_addr = addr ^ (({$random(seed), $random(seed)} | 64'h1) << IDX_W);
    len        = dbg_len_t'(MAX_LEN);
    run_write(addr, len);
    run_read(alias_addr, len);
    run_exec({$random(seed), $random(seed)});
    run_eoc(dbg_word_t'($random(seed)));
    run_challenge(1'b1);
    run_challenge(1'b0);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uart_dbg_top.f */
+incdir+src
+incdir+tests
src/uart_dbg_pkg.sv
src/uart_byte_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/dbg_mem.sv
src/dbg_cmd_engine.sv
src/uart_dbg_top.sv
tests/tb_uart_dbg_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_uart_dbg_top \
  -f uart_dbg_top.f -o sim_uart_dbg \
  && ./obj_dir/sim_uart_dbg > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log && echo "run.sh: passed" || { echo "run.sh: failed"; exit 1; }
